// ==== filelist.f ====
logic/axi_read_pkg.sv
logic/route_map_pkg.sv
logic/region_decoder.sv
logic/decerr_beat_counter.sv
logic/read_return_mux.sv
logic/read_route_fsm.sv
logic/axi_read_router.sv
verif/axi_read_router_assert.sv
verif/axi_read_router_tb.sv

// ==== logic/axi_read_pkg.sv ====
// AXI4 read-channel field widths, field types and response codes.
// Shared by the router blocks and the testbench client models.

`default_nettype none

package axi_read_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////////////////////////

    localparam int ADDR_WIDTH = 34;
    localparam int ID_WIDTH   = 4;
    localparam int DATA_WIDTH = 32;

    //////////////////////////////////////////////////////////////////////
    // AR and R field types
    //////////////////////////////////////////////////////////////////////

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [ID_WIDTH-1:0]   id_t;
    typedef logic [DATA_WIDTH-1:0] data_t;

    // Beats per burst minus one
    typedef logic [7:0] len_t;
    typedef logic [2:0] size_t;
    typedef logic [1:0] burst_t;
    typedef logic [2:0] prot_t;
    typedef logic [1:0] resp_t;

    //////////////////////////////////////////////////////////////////////
    // Response codes
    //////////////////////////////////////////////////////////////////////

    localparam resp_t RESP_OKAY   = 2'b00;
    // Returned for addresses outside every region
    localparam resp_t RESP_DECERR = 2'b11;

endpackage

`default_nettype wire

// ==== logic/axi_read_router.sv ====
// 1-to-N AXI4 read router top level. One upstream AR/R port is routed to
// the client that owns the address; unmapped reads get a DECERR burst.

`timescale 1ns/1ns
`default_nettype none

module axi_read_router #(
    parameter int NUM_CLIENTS  = 2,
    parameter int REGION_COUNT = 3,
    parameter axi_read_pkg::addr_t REGION_BASE [REGION_COUNT] =
        '{34'h0_0000, 34'h1_0000, 34'h2_0000},
    parameter axi_read_pkg::addr_t REGION_END [REGION_COUNT] =
        '{34'h0_1000, 34'h1_4000, 34'h2_1000},
    // Region 2 lands at client-0 addresses 0x1000 and up
    parameter axi_read_pkg::addr_t REGION_CLIENT_BASE [REGION_COUNT] =
        '{34'h0_0000, 34'h1_0000, 34'h1_F000},
    parameter route_map_pkg::client_idx_t REGION_CLIENT [REGION_COUNT] =
        '{2'd0, 2'd1, 2'd0}
) (
    input  wire                                         clk,
    input  wire                                         rst_n,

    // Upstream AR
    input  wire                                         up_arvalid,
    output wire                                         up_arready,
    input  wire axi_read_pkg::addr_t                    up_araddr,
    input  wire axi_read_pkg::len_t                     up_arlen,
    input  wire axi_read_pkg::size_t                    up_arsize,
    input  wire axi_read_pkg::burst_t                   up_arburst,
    input  wire axi_read_pkg::id_t                      up_arid,
    input  wire                                         up_arlock,
    input  wire axi_read_pkg::prot_t                    up_arprot,

    // Upstream R
    output wire                                         up_rvalid,
    input  wire                                         up_rready,
    output wire axi_read_pkg::data_t                    up_rdata,
    output wire axi_read_pkg::resp_t                    up_rresp,
    output wire axi_read_pkg::id_t                      up_rid,
    output wire                                         up_rlast,

    // Downstream AR, packed by client
    output wire [NUM_CLIENTS-1:0]                       dn_arvalid,
    input  wire [NUM_CLIENTS-1:0]                       dn_arready,
    output wire axi_read_pkg::addr_t                    dn_araddr,
    output wire axi_read_pkg::len_t                     dn_arlen,
    output wire axi_read_pkg::size_t                    dn_arsize,
    output wire axi_read_pkg::burst_t                   dn_arburst,
    output wire axi_read_pkg::id_t                      dn_arid,
    output wire                                         dn_arlock,
    output wire axi_read_pkg::prot_t                    dn_arprot,

    // Downstream R, packed by client
    input  wire [NUM_CLIENTS-1:0]                       dn_rvalid,
    output wire [NUM_CLIENTS-1:0]                       dn_rready,
    input  wire [NUM_CLIENTS*axi_read_pkg::DATA_WIDTH-1:0] dn_rdata,
    input  wire [NUM_CLIENTS*2-1:0]                     dn_rresp,
    input  wire [NUM_CLIENTS*axi_read_pkg::ID_WIDTH-1:0] dn_rid,
    input  wire [NUM_CLIENTS-1:0]                       dn_rlast
);

    import axi_read_pkg::*;
    import route_map_pkg::*;

    logic        dec_hit;
    logic        dec_load;
    client_idx_t sel_client;
    logic        cnt_load;
    logic        cnt_step;
    logic        cnt_last;
    logic        err_beat;
    id_t         err_id;
    logic        up_rvalid_gate;

    // Only the address is rebased
    assign dn_arlen   = up_arlen;
    assign dn_arsize  = up_arsize;
    assign dn_arburst = up_arburst;
    assign dn_arid    = up_arid;
    assign dn_arlock  = up_arlock;
    assign dn_arprot  = up_arprot;

    read_route_fsm #(
        .NUM_CLIENTS (NUM_CLIENTS)
    ) u_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .up_arvalid     (up_arvalid),
        .up_rready      (up_rready),
        .dec_hit        (dec_hit),
        .sel_client     (sel_client),
        .dn_arready     (dn_arready),
        .dn_rvalid      (dn_rvalid),
        .dn_rlast       (dn_rlast),
        .cnt_last       (cnt_last),
        .up_arready     (up_arready),
        .up_rvalid_gate (up_rvalid_gate),
        .dn_arvalid     (dn_arvalid),
        .dn_rready      (dn_rready),
        .dec_load       (dec_load),
        .cnt_load       (cnt_load),
        .cnt_step       (cnt_step),
        .err_beat       (err_beat)
    );

    region_decoder #(
        .NUM_CLIENTS        (NUM_CLIENTS),
        .REGION_COUNT       (REGION_COUNT),
        .REGION_BASE        (REGION_BASE),
        .REGION_END         (REGION_END),
        .REGION_CLIENT_BASE (REGION_CLIENT_BASE),
        .REGION_CLIENT      (REGION_CLIENT)
    ) u_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .araddr     (up_araddr),
        .dec_load   (dec_load),
        .dec_hit    (dec_hit),
        .sel_client (sel_client),
        .dn_araddr  (dn_araddr)
    );

    decerr_beat_counter u_counter (
        .clk      (clk),
        .rst_n    (rst_n),
        .cnt_load (cnt_load),
        .arlen    (up_arlen),
        .arid     (up_arid),
        .cnt_step (cnt_step),
        .cnt_last (cnt_last),
        .err_id   (err_id)
    );

    read_return_mux #(
        .NUM_CLIENTS (NUM_CLIENTS)
    ) u_return_mux (
        .sel_client     (sel_client),
        .err_beat       (err_beat),
        .err_id         (err_id),
        .up_rvalid_gate (up_rvalid_gate),
        .dn_rdata       (dn_rdata),
        .dn_rresp       (dn_rresp),
        .dn_rid         (dn_rid),
        .dn_rlast       (dn_rlast),
        .dn_rvalid      (dn_rvalid),
        .cnt_last       (cnt_last),
        .up_rvalid      (up_rvalid),
        .up_rdata       (up_rdata),
        .up_rresp       (up_rresp),
        .up_rid         (up_rid),
        .up_rlast       (up_rlast)
    );

endmodule

`default_nettype wire

// ==== logic/decerr_beat_counter.sv ====
// Beat counter for locally generated DECERR bursts. Loaded with arlen and
// the AR id on a decode miss, stepped once per accepted error beat.

`timescale 1ns/1ns
`default_nettype none

module decerr_beat_counter (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    cnt_load,
    input  wire axi_read_pkg::len_t arlen,
    input  wire axi_read_pkg::id_t  arid,
    input  wire                    cnt_step,
    output logic                   cnt_last,
    output axi_read_pkg::id_t      err_id
);

    import axi_read_pkg::*;

    // Beats still to send after the current one
    len_t beats_left;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beats_left <= '0;
        end else if (cnt_load) begin
            beats_left <= arlen;
        end else if (cnt_step && beats_left != '0) begin
            beats_left <= beats_left - 1'b1;
        end
    end

    // Echoed on every error beat
    always_ff @(posedge clk) begin
        if (cnt_load) begin
            err_id <= arid;
        end
    end

    assign cnt_last = (beats_left == '0);

endmodule

`default_nettype wire

// ==== logic/read_return_mux.sv ====
// Upstream R channel source. Picks the selected client's R slice, or
// builds a DECERR beat while the controller is in the error state.

`timescale 1ns/1ns
`default_nettype none

module read_return_mux #(
    parameter int NUM_CLIENTS = 2
) (
    input  wire route_map_pkg::client_idx_t             sel_client,
    input  wire                                         err_beat,
    input  wire axi_read_pkg::id_t                      err_id,
    input  wire                                         up_rvalid_gate,
    input  wire [NUM_CLIENTS*axi_read_pkg::DATA_WIDTH-1:0] dn_rdata,
    input  wire [NUM_CLIENTS*2-1:0]                     dn_rresp,
    input  wire [NUM_CLIENTS*axi_read_pkg::ID_WIDTH-1:0] dn_rid,
    input  wire [NUM_CLIENTS-1:0]                       dn_rlast,
    input  wire [NUM_CLIENTS-1:0]                       dn_rvalid,
    input  wire                                         cnt_last,
    output logic                                        up_rvalid,
    output axi_read_pkg::data_t                         up_rdata,
    output axi_read_pkg::resp_t                         up_rresp,
    output axi_read_pkg::id_t                           up_rid,
    output logic                                        up_rlast
);

    import axi_read_pkg::*;
    import route_map_pkg::*;

    logic  sel_valid;
    data_t sel_data;
    resp_t sel_resp;
    id_t   sel_id;
    logic  sel_last;

    // Slice of the selected client
    always_comb begin
        sel_valid = 1'b0;
        sel_data  = '0;
        sel_resp  = RESP_OKAY;
        sel_id    = '0;
        sel_last  = 1'b0;
        for (int c = 0; c < NUM_CLIENTS; c++) begin
            if (sel_client == client_idx_t'(c)) begin
                sel_valid = dn_rvalid[c];
                sel_data  = dn_rdata[c*DATA_WIDTH +: DATA_WIDTH];
                sel_resp  = dn_rresp[c*2 +: 2];
                sel_id    = dn_rid[c*ID_WIDTH +: ID_WIDTH];
                sel_last  = dn_rlast[c];
            end
        end
    end

    always_comb begin
        if (err_beat) begin
            up_rvalid = 1'b1;
            up_rdata  = '0;
            up_rresp  = RESP_DECERR;
            up_rid    = err_id;
            up_rlast  = cnt_last;
        end else begin
            up_rvalid = sel_valid & up_rvalid_gate;
            up_rdata  = sel_data;
            up_rresp  = sel_resp;
            up_rid    = sel_id;
            up_rlast  = sel_last;
        end
    end

endmodule

`default_nettype wire

// ==== logic/read_route_fsm.sv ====
// Route controller of the read router. Decides between routing and a
// local DECERR burst and gates every AR and R handshake.

`timescale 1ns/1ns
`default_nettype none

module read_route_fsm #(
    parameter int NUM_CLIENTS = 2
) (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                up_arvalid,
    input  wire                                up_rready,
    input  wire                                dec_hit,
    input  wire route_map_pkg::client_idx_t    sel_client,
    input  wire [NUM_CLIENTS-1:0]              dn_arready,
    input  wire [NUM_CLIENTS-1:0]              dn_rvalid,
    input  wire [NUM_CLIENTS-1:0]              dn_rlast,
    input  wire                                cnt_last,
    output logic                               up_arready,
    output logic                               up_rvalid_gate,
    output logic [NUM_CLIENTS-1:0]             dn_arvalid,
    output logic [NUM_CLIENTS-1:0]             dn_rready,
    output logic                               dec_load,
    output logic                               cnt_load,
    output logic                               cnt_step,
    output logic                               err_beat
);

    import route_map_pkg::*;

    route_state_t state, state_nxt;
    logic         ar_done, ar_done_nxt;
    logic         r_done, r_done_nxt;

    logic sel_arready;
    logic sel_rvalid;
    logic sel_rlast;

    //////////////////////////////////////////////////////////////////////
    // Selected client view
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        sel_arready = 1'b0;
        sel_rvalid  = 1'b0;
        sel_rlast   = 1'b0;
        for (int c = 0; c < NUM_CLIENTS; c++) begin
            if (sel_client == client_idx_t'(c)) begin
                sel_arready = dn_arready[c];
                sel_rvalid  = dn_rvalid[c];
                sel_rlast   = dn_rlast[c];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Next state and handshake gating
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt      = state;
        ar_done_nxt    = ar_done;
        r_done_nxt     = r_done;
        up_arready     = 1'b0;
        up_rvalid_gate = 1'b0;
        dn_arvalid     = '0;
        dn_rready      = '0;
        dec_load       = 1'b0;
        cnt_load       = 1'b0;
        cnt_step       = 1'b0;
        err_beat       = 1'b0;

        case (state)
            ROUTE_IDLE: begin
                if (up_arvalid) begin
                    if (dec_hit) begin
                        dec_load  = 1'b1;
                        state_nxt = ROUTE_ACTIVE;
                    end else begin
                        // Miss is accepted right away
                        up_arready = 1'b1;
                        cnt_load   = 1'b1;
                        state_nxt  = ROUTE_DECERR;
                    end
                end
            end

            ROUTE_ACTIVE: begin
                for (int c = 0; c < NUM_CLIENTS; c++) begin
                    if (sel_client == client_idx_t'(c)) begin
                        dn_arvalid[c] = up_arvalid & ~ar_done;
                        dn_rready[c]  = up_rready & ~r_done;
                    end
                end
                up_arready     = sel_arready & ~ar_done;
                up_rvalid_gate = ~r_done;

                if (up_arvalid && up_arready) begin
                    ar_done_nxt = 1'b1;
                end
                if (sel_rvalid && sel_rlast && up_rready && !r_done) begin
                    r_done_nxt = 1'b1;
                end

                // Both channels finished
                if (ar_done_nxt && r_done_nxt) begin
                    state_nxt   = ROUTE_IDLE;
                    ar_done_nxt = 1'b0;
                    r_done_nxt  = 1'b0;
                end
            end

            ROUTE_DECERR: begin
                err_beat = 1'b1;
                cnt_step = up_rready;
                if (up_rready && cnt_last) begin
                    state_nxt = ROUTE_IDLE;
                end
            end

            default: begin
                state_nxt = ROUTE_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ROUTE_IDLE;
            ar_done <= 1'b0;
            r_done  <= 1'b0;
        end else begin
            state   <= state_nxt;
            ar_done <= ar_done_nxt;
            r_done  <= r_done_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== logic/region_decoder.sv ====
// Address region lookup for the read router. Compares the upstream AR
// address with the region table and latches client and local address.

`timescale 1ns/1ns
`default_nettype none

module region_decoder #(
    parameter int NUM_CLIENTS  = 2,
    parameter int REGION_COUNT = 1,
    parameter axi_read_pkg::addr_t REGION_BASE [REGION_COUNT] = '{default: '0},
    parameter axi_read_pkg::addr_t REGION_END [REGION_COUNT] = '{default: '0},
    parameter axi_read_pkg::addr_t REGION_CLIENT_BASE [REGION_COUNT] = '{default: '0},
    parameter route_map_pkg::client_idx_t REGION_CLIENT [REGION_COUNT] = '{default: '0}
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire axi_read_pkg::addr_t     araddr,
    input  wire                          dec_load,
    output logic                         dec_hit,
    output route_map_pkg::client_idx_t   sel_client,
    output axi_read_pkg::addr_t          dn_araddr
);

    import axi_read_pkg::*;
    import route_map_pkg::*;

    client_idx_t hit_client;
    addr_t       hit_addr;

    // Later regions override earlier ones on overlap.
    // A region pointing at a missing client never matches
    always_comb begin
        dec_hit    = 1'b0;
        hit_client = '0;
        hit_addr   = '0;
        for (int i = 0; i < REGION_COUNT; i++) begin
            if (araddr >= REGION_BASE[i] && araddr < REGION_END[i]
                    && int'(REGION_CLIENT[i]) < NUM_CLIENTS) begin
                dec_hit    = 1'b1;
                hit_client = REGION_CLIENT[i];
                hit_addr   = araddr - REGION_CLIENT_BASE[i];
            end
        end
    end

    // Held for the whole transaction
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel_client <= '0;
        end else if (dec_load) begin
            sel_client <= hit_client;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_load) begin
            dn_araddr <= hit_addr;
        end
    end

endmodule

`default_nettype wire

// ==== logic/route_map_pkg.sv ====
// Routing types: the client number carried through the router and the
// states of the route controller.

`default_nettype none

package route_map_pkg;

    // Up to four downstream clients
    localparam int CLIENT_BITS = 2;

    typedef logic [CLIENT_BITS-1:0] client_idx_t;

    // Route controller states
    typedef enum logic [1:0] {
        ROUTE_IDLE,
        ROUTE_ACTIVE,
        ROUTE_DECERR
    } route_state_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds the router testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module axi_read_router_tb -o axi_read_router_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/axi_read_router_sim > sim.log 2>&1 \
    || echo "SIMULATION FAILED" >> sim.log

grep -q "SIMULATION FAILED" sim.log \
    && { echo "Result: FAIL, see sim.log"; exit 1; } \
    || { echo "Result: PASS"; exit 0; }

// ==== verif/axi_read_router_assert.sv ====
// Concurrent checks on the route controller handshakes.
// Attached to read_route_fsm with a bind from the testbench.

`timescale 1ns/1ns
`default_nettype none

module axi_read_router_assert #(
    parameter int NUM_CLIENTS = 2
) (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire route_map_pkg::route_state_t  state,
    input  wire                               up_arready,
    input  wire                               up_rvalid_gate,
    input  wire                               err_beat,
    input  wire [NUM_CLIENTS-1:0]             dn_arvalid,
    input  wire [NUM_CLIENTS-1:0]             dn_rready
);

    import route_map_pkg::*;

    // At most one client addressed
    arvalid_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(dn_arvalid))
        else $error("dn_arvalid drives more than one client");

    rready_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(dn_rready))
        else $error("dn_rready drives more than one client");

    arvalid_only_active: assert property (@(posedge clk) disable iff (!rst_n)
        (state != ROUTE_ACTIVE) |-> (dn_arvalid == '0))
        else $error("dn_arvalid high outside ACTIVE");

    // First cycle out of reset is quiet
    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (!up_arready && !up_rvalid_gate && !err_beat))
        else $error("handshake active in the first cycle after reset");

endmodule

`default_nettype wire

// ==== verif/axi_read_router_tb.sv ====
// Directed testbench for the AXI4 read router. Two client models answer
// routed reads, and every test drives the upstream port and checks each beat.

`timescale 1ns/1ns
`default_nettype none

module axi_read_router_tb;

    import axi_read_pkg::*;

    localparam int     NUM_TESTS   = 6;
    localparam longint WATCHDOG_NS = longint'(NUM_TESTS) * 256 * 16 * 8;

    // Expected region map with exclusive end bounds
    localparam addr_t MAP_BASE  [3] = '{34'h0_0000, 34'h1_0000, 34'h2_0000};
    localparam addr_t MAP_END   [3] = '{34'h0_1000, 34'h1_4000, 34'h2_1000};
    localparam addr_t MAP_CBASE [3] = '{34'h0_0000, 34'h1_0000, 34'h1_F000};
    localparam int    MAP_CLIENT[3] = '{0, 1, 0};

    logic   clk;
    logic   rst_n;
    integer seed = 24;
    int     checks = 0;
    int     errors = 0;

    // Upstream port
    logic        up_arvalid;
    wire         up_arready;
    addr_t       up_araddr;
    len_t        up_arlen;
    size_t       up_arsize;
    burst_t      up_arburst;
    id_t         up_arid;
    logic        up_arlock;
    prot_t       up_arprot;
    wire         up_rvalid;
    logic        up_rready = 1'b0;
    wire data_t  up_rdata;
    wire resp_t  up_rresp;
    wire id_t    up_rid;
    wire         up_rlast;

    // Downstream ports packed by client
    wire [1:0]   dn_arvalid;
    wire [1:0]   dn_arready;
    wire addr_t  dn_araddr;
    wire len_t   dn_arlen;
    wire size_t  dn_arsize;
    wire burst_t dn_arburst;
    wire id_t    dn_arid;
    wire         dn_arlock;
    wire prot_t  dn_arprot;
    wire [1:0]   dn_rvalid;
    wire [1:0]   dn_rready;
    wire [63:0]  dn_rdata;
    wire [3:0]   dn_rresp;
    wire [7:0]   dn_rid;
    wire [1:0]   dn_rlast;

    // Client model state
    logic [1:0] cl_arready = '0;
    logic [1:0] cl_rvalid  = '0;
    logic [1:0] cl_rlast   = '0;
    logic [1:0] cl_busy    = '0;
    logic [1:0] cl_lock    = '0;
    addr_t      cl_addr  [2] = '{default: '0};
    len_t       cl_len   [2] = '{default: '0};
    len_t       cl_beat  [2] = '{default: '0};
    id_t        cl_id    [2] = '{default: '0};
    size_t      cl_size  [2] = '{default: '0};
    burst_t     cl_burst [2] = '{default: '0};
    prot_t      cl_prot  [2] = '{default: '0};
    data_t      cl_rdata [2] = '{default: '0};
    int         ar_count [2] = '{0, 0};
    int         exp_ar   [2] = '{0, 0};

    assign dn_arready = cl_arready;
    assign dn_rvalid  = cl_rvalid;
    assign dn_rlast   = cl_rlast;
    assign dn_rdata   = {cl_rdata[1], cl_rdata[0]};
    assign dn_rid     = {cl_id[1], cl_id[0]};
    assign dn_rresp   = {RESP_OKAY, RESP_OKAY};

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    axi_read_router UUT (.*);

    bind read_route_fsm axi_read_router_assert #(
        .NUM_CLIENTS (NUM_CLIENTS)
    ) u_assert (
        .clk            (clk),
        .rst_n          (rst_n),
        .state          (state),
        .up_arready     (up_arready),
        .up_rvalid_gate (up_rvalid_gate),
        .err_beat       (err_beat),
        .dn_arvalid     (dn_arvalid),
        .dn_rready      (dn_rready)
    );

    // Client read data from client number, beat index and local address
    function automatic data_t beat_data(int client, addr_t local_addr, int beat);
        return {4'hA, 2'(client), 2'b00, 8'(beat), local_addr[15:0]};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Client models and upstream rready stalls
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst_n) begin
            up_rready  <= 1'b0;
            cl_arready <= '0;
            cl_rvalid  <= '0;
            cl_busy    <= '0;
        end else begin
            up_rready <= (($random(seed) & 3) != 0);
            for (int c = 0; c < 2; c++) begin
                if (!cl_busy[c]) begin
                    if (dn_arvalid[c] && cl_arready[c]) begin
                        cl_arready[c] <= 1'b0;
                        cl_busy[c]    <= 1'b1;
                        cl_addr[c]    <= dn_araddr;
                        cl_len[c]     <= dn_arlen;
                        cl_id[c]      <= dn_arid;
                        cl_size[c]    <= dn_arsize;
                        cl_burst[c]   <= dn_arburst;
                        cl_lock[c]    <= dn_arlock;
                        cl_prot[c]    <= dn_arprot;
                        cl_beat[c]    <= '0;
                        ar_count[c]   <= ar_count[c] + 1;
                    end else begin
                        cl_arready[c] <= (($random(seed) & 3) == 0);
                    end
                end else if (cl_rvalid[c]) begin
                    if (dn_rready[c]) begin
                        cl_rvalid[c] <= 1'b0;
                        cl_beat[c]   <= cl_beat[c] + 8'd1;
                        if (cl_rlast[c]) begin
                            cl_busy[c] <= 1'b0;
                        end
                    end
                end else if (($random(seed) & 1) != 0) begin
                    cl_rvalid[c] <= 1'b1;
                    cl_rdata[c]  <= beat_data(c, cl_addr[c], int'(cl_beat[c]));
                    cl_rlast[c]  <= (cl_beat[c] == cl_len[c]);
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_data(input data_t act, input data_t exp, input string what);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %0t: %s is %h, expected %h", $time, what, act, exp);
        end
    endtask

    task automatic check_resp(input resp_t act, input resp_t exp, input string what);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %0t: %s is %b, expected %b", $time, what, act, exp);
        end
    endtask

    task automatic check_id(input id_t act, input id_t exp, input string what);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %0t: %s is %h, expected %h", $time, what, act, exp);
        end
    endtask

    task automatic check_addr(input addr_t act, input addr_t exp, input string what);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %0t: %s is %h, expected %h", $time, what, act, exp);
        end
    endtask

    task automatic check_last(input bit act, input bit exp, input string what);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %0t: %s is %b, expected %b", $time, what, act, exp);
        end
    endtask

    task automatic check_size(input size_t act, input size_t exp, input string what);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %0t: %s is %h, expected %h", $time, what, act, exp);
        end
    endtask

    task automatic check_burst(input burst_t act, input burst_t exp, input string what);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %0t: %s is %b, expected %b", $time, what, act, exp);
        end
    endtask

    task automatic check_lock(input bit act, input bit exp, input string what);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %0t: %s is %b, expected %b", $time, what, act, exp);
        end
    endtask

    task automatic check_prot(input prot_t act, input prot_t exp, input string what);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %0t: %s is %b, expected %b", $time, what, act, exp);
        end
    endtask

    task automatic check_ar_counts();
        for (int c = 0; c < 2; c++) begin
            checks++;
            if (ar_count[c] != exp_ar[c]) begin
                errors++;
                $display("FAILED %0t: client %0d saw %0d ARs, expected %0d",
                         $time, c, ar_count[c], exp_ar[c]);
            end
        end
    endtask

    // Highest-numbered matching region wins
    task automatic map_address(input addr_t addr, output bit hit, output int client,
                               output addr_t local_addr);
        hit        = 1'b0;
        client     = 0;
        local_addr = '0;
        for (int r = 0; r < 3; r++) begin
            if (addr >= MAP_BASE[r] && addr < MAP_END[r]) begin
                hit        = 1'b1;
                client     = MAP_CLIENT[r];
                local_addr = addr - MAP_CBASE[r];
            end
        end
    endtask

    // One full read with its AR handshake and every R beat checked against the map
    task automatic run_read(input addr_t addr, input len_t len, input id_t id);
        bit     hit;
        int     client;
        addr_t  local_addr;
        data_t  exp_data;
        size_t  size;
        burst_t burst;
        bit     lock;
        prot_t  prot;
        map_address(addr, hit, client, local_addr);
        // Side-band AR fields change from read to read
        size  = 3'd2 - size_t'($random(seed) & 1);
        burst = burst_t'($random(seed) & 1);
        lock  = (($random(seed) & 1) != 0);
        prot  = prot_t'($random(seed));
        @(posedge clk);
        up_arvalid <= 1'b1;
        up_araddr  <= addr;
        up_arlen   <= len;
        up_arsize  <= size;
        up_arburst <= burst;
        up_arid    <= id;
        up_arlock  <= lock;
        up_arprot  <= prot;
        @(posedge clk);
        while (!up_arready) @(posedge clk);
        up_arvalid <= 1'b0;
        if (hit) begin
            exp_ar[client]++;
        end
        for (int i = 0; i <= int'(len); i++) begin
            @(posedge clk);
            while (!(up_rvalid && up_rready)) @(posedge clk);
            exp_data = hit ? beat_data(client, local_addr, i) : '0;
            check_data(up_rdata, exp_data, "rdata");
            check_resp(up_rresp, hit ? RESP_OKAY : RESP_DECERR, "rresp");
            check_id(up_rid, id, "rid");
            check_last(up_rlast, i == int'(len), "rlast");
        end
        if (hit) begin
            check_addr(cl_addr[client], local_addr, "client araddr");
            check_size(cl_size[client], size, "client arsize");
            check_burst(cl_burst[client], burst, "client arburst");
            check_lock(cl_lock[client], lock, "client arlock");
            check_prot(cl_prot[client], prot, "client arprot");
        end
        check_ar_counts();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        checks++;
        if (up_arready !== 1'b0 || up_rvalid !== 1'b0
                || dn_arvalid !== 2'b00 || dn_rready !== 2'b00) begin
            errors++;
            $display("FAILED %0t: handshake outputs not low after reset", $time);
        end
        check_ar_counts();
    endtask

    task automatic test_random_mix();
        addr_t addr;
        int    pick;
        for (int n = 0; n < 20; n++) begin
            pick = $random(seed) & 3;
            case (pick)
                0: addr = 34'h0_0000 + addr_t'($random(seed) & 32'h0FFC);
                1: addr = 34'h1_0000 + addr_t'($random(seed) & 32'h3FFC);
                2: addr = 34'h2_0000 + addr_t'($random(seed) & 32'h0FFC);
                // Holes below region 2 and above the map
                default: addr = ((($random(seed) & 1) != 0) ? 34'h1_8000 : 34'h3_0000)
                                + addr_t'($random(seed) & 32'h0FFC);
            endcase
            run_read(addr, len_t'($random(seed) & 7), id_t'($random(seed)));
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        up_arvalid = 1'b0;
        up_araddr  = '0;
        up_arlen   = '0;
        up_arsize  = 3'd2;
        up_arburst = 2'b01;
        up_arid    = '0;
        up_arlock  = 1'b0;
        up_arprot  = '0;
        test_reset();
        run_read(34'h0_0040, 8'd0, 4'h5);
        run_read(34'h1_2100, 8'd7, 4'hA);
        run_read(34'h2_0080, 8'd1, 4'h3);
        run_read(34'h0_8000, 8'd3, 4'hC);
        test_random_mix();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: a read never completed");
        errors++;
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire
